// ==== rtl/sha_params.svh ====
// Datapath widths, debounce and rate defaults, and the two constant message blocks
`ifndef SHA_PARAMS_SVH
`define SHA_PARAMS_SVH

// Datapath widths
`define SHA_WORD_W 32
`define SHA_OPS_W 48 // Total hash count
`define SHA_RATE_W 32 // Hashes per interval
`define SHA_ROUNDS 64

// Button and rate timing at 48 MHz
`define SHA_PRESS_CYCLES 240000 // 5 ms
`define SHA_LONG_CYCLES 2097152 // Long press threshold
`define SHA_RELEASE_CYCLES 4800000 // 100 ms
`define SHA_RATE_CYCLES 48000000 // One second

// "abcdbcdecdefdefg...nopq", then the 0x80 pad byte
`define SHA_BLOCK0 { \
	32'h61626364, 32'h62636465, 32'h63646566, 32'h64656667, \
	32'h65666768, 32'h66676869, 32'h6768696a, 32'h68696a6b, \
	32'h696a6b6c, 32'h6a6b6c6d, 32'h6b6c6d6e, 32'h6c6d6e6f, \
	32'h6d6e6f70, 32'h6e6f7071, 32'h80000000, 32'h00000000 }

// Zero fill, message length in bits last (448)
`define SHA_BLOCK1 {480'h0, 32'h000001c0}

`endif

// ==== rtl/sha_pkg.sv ====
// Shared SHA-256 types, round constant lookup and initial hash value
`default_nettype none
`include "sha_params.svh"

package sha_pkg;

	typedef logic [`SHA_WORD_W-1:0] sha_word_t;
	typedef sha_word_t [15:0] sha_block_t; // First message word in [15]

	// Working variables, also the digest H0..H7
	typedef struct packed {
		sha_word_t a, b, c, d, e, f, g, h;
	} sha_digest_t;

	typedef struct packed {
		logic press; // One-cycle strobe
		logic hold; // Level while held long
	} button_evt_t;

	typedef struct packed {
		logic [`SHA_OPS_W-1:0] op_count;
		logic [`SHA_RATE_W-1:0] ops_per_interval;
	} op_stats_t;

	// Round constants K0..K63, index 0 first
	localparam sha_word_t [0:63] SHA_K = {
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
		32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
		32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
		32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
		32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
		32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	function automatic sha_word_t sha_k(input logic [5:0] idx);
		return SHA_K[idx];
	endfunction

	// FIPS 180-4 section 5.3.3
	function automatic sha_digest_t sha_iv();
		return '{32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
			32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};
	endfunction

endpackage

`default_nettype wire

// ==== rtl/button_debounce.sv ====
// Fire button synchronizer and press/hold debounce FSM
`default_nettype none
`include "sha_params.svh"

module button_debounce import sha_pkg::*; #(
	parameter int PRESS_CYCLES = `SHA_PRESS_CYCLES,
	parameter int LONG_CYCLES = `SHA_LONG_CYCLES,
	parameter int RELEASE_CYCLES = `SHA_RELEASE_CYCLES
) (
	input logic clk,
	input logic reset,
	input logic button,
	output button_evt_t evt
);
	localparam int HELD_W = $clog2(LONG_CYCLES + 1);
	localparam int OFF_W = $clog2(RELEASE_CYCLES + 1);

	typedef enum logic [2:0] {
		S_IDLE, S_WAIT_PRESS, S_PULSE, S_WAIT_LONG, S_LONG, S_WAIT_OFF, S_WAIT_LOFF
	} state_t;

	logic [2:0] meta; // Metastability chain
	logic btn; // Synchronized button
	state_t state;
	logic [HELD_W-1:0] held_cnt; // Cycles since leaving idle
	logic [OFF_W-1:0] off_cnt; // Cycles released
	logic press_done;
	logic long_done;
	logic off_done;

	always_ff @(posedge clk) begin
		if (reset) begin
			{btn, meta} <= '0;
		end else begin
			{btn, meta} <= {meta, button}; // Four cycles to btn
		end
	end

	assign press_done = held_cnt == HELD_W'(PRESS_CYCLES);
	assign long_done = held_cnt == HELD_W'(LONG_CYCLES);
	assign off_done = off_cnt == OFF_W'(RELEASE_CYCLES);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			held_cnt <= '0;
			off_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: state <= btn ? S_WAIT_PRESS : S_IDLE;
				S_WAIT_PRESS: state <= !btn ? S_IDLE : (press_done ? S_PULSE : S_WAIT_PRESS);
				S_PULSE: state <= S_WAIT_LONG; // Press strobe for one cycle
				S_WAIT_LONG: state <= !btn ? S_WAIT_OFF : (long_done ? S_LONG : S_WAIT_LONG);
				S_LONG: state <= btn ? S_LONG : S_WAIT_LOFF;
				S_WAIT_OFF: state <= btn ? S_WAIT_LONG : (off_done ? S_IDLE : S_WAIT_OFF);
				S_WAIT_LOFF: state <= btn ? S_LONG : (off_done ? S_IDLE : S_WAIT_LOFF);
				default: state <= S_IDLE;
			endcase
			// Press time saturates at the long threshold
			held_cnt <= (state == S_IDLE) ? '0 : (long_done ? held_cnt : held_cnt + 1'b1);
			off_cnt <= (state == S_WAIT_OFF || state == S_WAIT_LOFF) ? off_cnt + 1'b1 : '0;
		end
	end

	assign evt = '{press: state == S_PULSE,
		hold: state == S_LONG || state == S_WAIT_LOFF}; // Hold covers release wait

	// Short and long events never overlap
	a_press_hold: assert property (@(posedge clk) disable iff (reset)
		!(evt.press && evt.hold));

endmodule

`default_nettype wire

// ==== rtl/sha_schedule.sv ====
// Rolling 16-word SHA-256 message schedule
`default_nettype none

module sha_schedule import sha_pkg::*; (
	input logic clk,
	input logic reset,
	input logic load,
	input sha_block_t block,
	input logic advance,
	output sha_word_t w
);
	sha_block_t win; // W[t] in [15], W[t+15] in [0]
	sha_word_t w_next;

	// Small sigma 0
	function automatic sha_word_t ssig0(input sha_word_t x);
		return {x[6:0], x[31:7]} ^ {x[17:0], x[31:18]} ^ (x >> 3);
	endfunction

	// Small sigma 1
	function automatic sha_word_t ssig1(input sha_word_t x);
		return {x[16:0], x[31:17]} ^ {x[18:0], x[31:19]} ^ (x >> 10);
	endfunction

	// W[t+16] from W[t+14], W[t+9], W[t+1], W[t]
	assign w_next = ssig1(win[1]) + win[6] + ssig0(win[14]) + win[15];

	always_ff @(posedge clk) begin
		if (reset) begin
			win <= '0;
		end else if (load) begin
			win <= block; // Words 0..15 straight from the block
		end else if (advance) begin
			win <= {win[14:0], w_next};
		end
	end

	assign w = win[15]; // Current round word

endmodule

`default_nettype wire

// ==== rtl/sha_core.sv ====
// SHA-256 compression engine, one round per clock, chained across blocks
`default_nettype none
`include "sha_params.svh"

module sha_core import sha_pkg::*; (
	input logic clk,
	input logic reset,
	input logic block_valid,
	input sha_block_t block,
	input logic first_block,
	output logic block_done,
	output sha_digest_t block_digest,
	output logic busy
);
	localparam logic [5:0] LAST_RND = 6'(`SHA_ROUNDS - 1);

	logic running; // Rounds in progress
	logic adding; // Chaining add cycle
	logic [5:0] rnd;
	sha_digest_t work; // a..h
	sha_digest_t chain; // H, held across blocks
	sha_digest_t chain_sum; // H plus final a..h
	sha_word_t w;
	sha_word_t ch;
	sha_word_t maj;
	sha_word_t t1;
	sha_word_t t2;

	// Big sigma 0
	function automatic sha_word_t bsig0(input sha_word_t x);
		return {x[1:0], x[31:2]} ^ {x[12:0], x[31:13]} ^ {x[21:0], x[31:22]};
	endfunction

	// Big sigma 1
	function automatic sha_word_t bsig1(input sha_word_t x);
		return {x[5:0], x[31:6]} ^ {x[10:0], x[31:11]} ^ {x[24:0], x[31:25]};
	endfunction

	sha_schedule schedule0 (
		.clk(clk), .reset(reset),
		.load(block_valid), .block(block),
		.advance(running), .w(w)
	);

	//////////////////////////////////////////////////
	// Round datapath
	//////////////////////////////////////////////////

	assign ch = (work.e & work.f) ^ (~work.e & work.g);
	assign maj = (work.a & work.b) ^ (work.a & work.c) ^ (work.b & work.c);
	assign t1 = work.h + bsig1(work.e) + ch + sha_k(rnd) + w;
	assign t2 = bsig0(work.a) + maj;

	assign chain_sum = '{chain.a + work.a, chain.b + work.b, chain.c + work.c,
		chain.d + work.d, chain.e + work.e, chain.f + work.f, chain.g + work.g,
		chain.h + work.h};

	always_ff @(posedge clk) begin
		if (block_valid) begin
			work <= first_block ? sha_iv() : chain; // New message or next block
		end else if (running) begin
			work <= '{a: t1 + t2, b: work.a, c: work.b, d: work.c,
				e: work.d + t1, f: work.e, g: work.f, h: work.g};
		end
		if (block_valid && first_block) begin
			chain <= sha_iv();
		end else if (adding) begin
			chain <= chain_sum;
		end
	end

	//////////////////////////////////////////////////
	// Round control
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			adding <= 1'b0;
			rnd <= '0;
		end else begin
			adding <= running && rnd == LAST_RND; // After round 64
			if (block_valid) begin
				running <= 1'b1;
				rnd <= '0;
			end else if (running) begin
				rnd <= rnd + 6'd1;
				running <= rnd != LAST_RND;
			end
		end
	end

	assign busy = running || adding;
	assign block_done = adding; // Sum valid in the add cycle
	assign block_digest = chain_sum;

	// Sequencer waits for idle before each block
	a_no_overlap: assert property (@(posedge clk) disable iff (reset)
		block_valid |-> !busy);

endmodule

`default_nettype wire

// ==== rtl/hash_sequencer.sv ====
// Hash start control, two-block issue and digest latch
`default_nettype none
`include "sha_params.svh"

module hash_sequencer import sha_pkg::*; (
	input logic clk,
	input logic reset,
	input button_evt_t evt,
	input logic block_done,
	input sha_digest_t block_digest,
	output logic block_valid,
	output sha_block_t block,
	output logic first_block,
	output sha_digest_t digest,
	output logic digest_valid,
	output logic busy
);
	typedef enum logic [1:0] {S_IDLE, S_BLK0, S_BLK1, S_FINISH} state_t;

	state_t state;
	logic start; // Issue block 0 next cycle

	// Press or hold from idle, or hold still there at the digest
	assign start = (state == S_IDLE && (evt.press || evt.hold))
		|| (state == S_FINISH && evt.hold);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			block_valid <= 1'b0;
			digest_valid <= 1'b0;
			digest <= '0;
		end else begin
			block_valid <= start || (state == S_BLK0 && block_done);
			digest_valid <= state == S_BLK1 && block_done;
			if (state == S_BLK1 && block_done) begin
				digest <= block_digest; // Final chaining value
			end
			case (state)
				S_IDLE: state <= start ? S_BLK0 : S_IDLE;
				S_BLK0: state <= block_done ? S_BLK1 : S_BLK0;
				S_BLK1: state <= block_done ? S_FINISH : S_BLK1;
				S_FINISH: state <= start ? S_BLK0 : S_IDLE; // Back to back on hold
				default: state <= S_IDLE;
			endcase
		end
	end

	// Block and first flag follow the state the strobe lands in
	assign block = (state == S_BLK1) ? `SHA_BLOCK1 : `SHA_BLOCK0;
	assign first_block = state == S_BLK0;
	assign busy = state != S_IDLE; // Through the digest_valid cycle

	// Next digest is at least two blocks away
	a_dv_pulse: assert property (@(posedge clk) disable iff (reset)
		digest_valid |=> !digest_valid);

endmodule

`default_nettype wire

// ==== rtl/op_stats.sv ====
// Total hash counter and per-interval rate latch
`default_nettype none
`include "sha_params.svh"

module op_stats import sha_pkg::*; #(
	parameter int RATE_CYCLES = `SHA_RATE_CYCLES
) (
	input logic clk,
	input logic reset,
	input logic digest_valid,
	output op_stats_t stats,
	output logic rate_update
);
	localparam int IVL_W = $clog2(RATE_CYCLES);

	logic [IVL_W-1:0] ivl_cnt; // Interval timer
	logic ivl_end;
	logic [`SHA_RATE_W-1:0] run_cnt; // Hashes so far this interval

	assign ivl_end = ivl_cnt == IVL_W'(RATE_CYCLES - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			ivl_cnt <= '0;
			rate_update <= 1'b0;
			run_cnt <= '0;
			stats <= '0;
		end else begin
			ivl_cnt <= ivl_end ? '0 : ivl_cnt + 1'b1;
			rate_update <= ivl_end; // Same cycle as the new latch value
			if (digest_valid) begin
				stats.op_count <= stats.op_count + 1'b1;
			end
			if (ivl_end) begin
				stats.ops_per_interval <= run_cnt + digest_valid;
				run_cnt <= '0;
			end else begin
				run_cnt <= run_cnt + digest_valid;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sha_chip.sv ====
// SHA-256 demonstrator top level with button, sequencer, core and statistics
`default_nettype none
`include "sha_params.svh"

module sha_chip import sha_pkg::*; #(
	parameter int PRESS_CYCLES = `SHA_PRESS_CYCLES,
	parameter int LONG_CYCLES = `SHA_LONG_CYCLES,
	parameter int RELEASE_CYCLES = `SHA_RELEASE_CYCLES,
	parameter int RATE_CYCLES = `SHA_RATE_CYCLES
) (
	input logic clk,
	input logic reset,
	input logic fire_button,
	output sha_digest_t digest,
	output logic digest_valid,
	output logic busy,
	output op_stats_t stats,
	output logic rate_update
);
	button_evt_t evt; // Debounced press and hold
	logic block_valid;
	sha_block_t block;
	logic first_block;
	logic block_done;
	sha_digest_t block_digest;

	//////////////////////////////////////////////////
	// Fire button and hash control
	//////////////////////////////////////////////////

	button_debounce #(
		.PRESS_CYCLES(PRESS_CYCLES),
		.LONG_CYCLES(LONG_CYCLES),
		.RELEASE_CYCLES(RELEASE_CYCLES)
	) debounce0 (
		.clk(clk), .reset(reset), .button(fire_button), .evt(evt)
	);

	hash_sequencer sequencer0 (
		.clk(clk), .reset(reset), .evt(evt),
		.block_done(block_done), .block_digest(block_digest),
		.block_valid(block_valid), .block(block), .first_block(first_block),
		.digest(digest), .digest_valid(digest_valid), .busy(busy)
	);

	// Core busy only feeds its own check
	sha_core core0 (
		.clk(clk), .reset(reset),
		.block_valid(block_valid), .block(block), .first_block(first_block),
		.block_done(block_done), .block_digest(block_digest), .busy()
	);

	op_stats #(.RATE_CYCLES(RATE_CYCLES)) stats0 (
		.clk(clk), .reset(reset), .digest_valid(digest_valid),
		.stats(stats), .rate_update(rate_update)
	);

endmodule

`default_nettype wire

// ==== verification/sha_chip_tb.sv ====
// Testbench for the SHA-256 button demonstrator with stimulus table, scoreboard and timeout
`default_nettype none
`include "sha_params.svh"

module sha_chip_tb import sha_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_ROWS = 6;
	localparam int HASH_CYCLES = 133; // Start to digest_valid
	localparam int MAX_GAP = 16; // Random idle between rows
	localparam int RATE_CYCLES = 2000; // Rate interval of the DUT

	// One button action and the digest count it should give
	typedef struct packed {
		int high; // Button high, cycles
		int low; // Button low afterwards
		int min_dv;
		int max_dv;
	} row_t;

	// Two-block "abcdbcdecdef..." vector, H0 first
	localparam sha_digest_t EXP_DIGEST = {
		32'h248d6a61, 32'hd20638b8, 32'he5c02693, 32'h0c3e6039,
		32'ha33ce459, 32'h64ff2167, 32'hf6ecedd4, 32'h19db06c1};

	row_t rows [N_ROWS] = '{
		'{60, 300, 1, 1}, // Short press
		'{10, 100, 0, 0}, // Glitch below press time
		'{1200, 600, 5, 14}, // Long hold, back to back
		'{40, 260, 1, 1},
		'{8, 120, 0, 0},
		'{900, 500, 3, 11}
	};

	logic clk;
	logic reset;
	logic fire_button;
	sha_digest_t digest;
	logic digest_valid;
	logic busy;
	op_stats_t stats;
	logic rate_update;

	int cycle_cnt = 0;
	int cycle_limit = 0; // Set before the first edge
	int dv_total = 0; // All digest_valid pulses
	int dv_row = 0; // Pulses in the current row
	int dv_ivl = 0; // Pulses since the last rate_update
	int busy_run = 0; // Busy cycles since rise or last digest
	int ivl_run = 0; // Cycles since reset or the last rate_update
	logic op_check = 1'b0; // op_count due this cycle

	sha_chip #(
		.PRESS_CYCLES(20), .LONG_CYCLES(400), .RELEASE_CYCLES(50), .RATE_CYCLES(RATE_CYCLES)
	) dut0 (
		.clk(clk), .reset(reset), .fire_button(fire_button), .digest(digest),
		.digest_valid(digest_valid), .busy(busy), .stats(stats), .rate_update(rate_update)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic stop_on_failure(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [255:0] got,
		input logic [255:0] exp);
		stop_on_failure($sformatf("ERROR %s: got %0h, expected %0h (cycle %0d)",
			name, got, exp, cycle_cnt));
	endtask

	// Level set 2 ns after an edge, then held
	task automatic drive_button(input logic level, input int cycles);
		fire_button = level;
		repeat (cycles) begin
			@(posedge clk);
			#2;
		end
	endtask

	// Table length plus nominal hash time, doubled
	function automatic int run_cycle_limit();
		int total;
		total = 4; // Reset cycles
		for (int r = 0; r < N_ROWS; r++) begin
			total += rows[r].high + rows[r].low + MAX_GAP + HASH_CYCLES * rows[r].max_dv;
		end
		return 2 * total;
	endfunction

	//////////////////////////////////////////////////
	// Scoreboard, sampled mid-cycle
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			stop_on_failure($sformatf("Timeout: run still going after %0d cycles", cycle_limit));
		end
		if (op_check) begin // One cycle after digest_valid
			assert (stats.op_count == `SHA_OPS_W'(dv_total)) else
				report_mismatch("stats.op_count", stats.op_count, dv_total);
			op_check = 1'b0;
		end
		if (rate_update) begin
			assert (ivl_run == RATE_CYCLES) else
				report_mismatch("rate_update period", ivl_run, RATE_CYCLES);
			assert (stats.ops_per_interval == `SHA_RATE_W'(dv_ivl)) else
				report_mismatch("stats.ops_per_interval", stats.ops_per_interval, dv_ivl);
			dv_ivl = 0; // New interval
			ivl_run = 0;
		end else if (ivl_run >= RATE_CYCLES) begin
			stop_on_failure("rate_update did not pulse at the end of an interval");
		end
		ivl_run = reset ? 0 : ivl_run + 1;
		busy_run = busy ? busy_run + 1 : 0;
		if (digest_valid) begin
			assert (digest == EXP_DIGEST) else
				report_mismatch("digest", digest, EXP_DIGEST);
			// busy from the cycle after the start through digest_valid
			assert (busy_run == HASH_CYCLES) else
				report_mismatch("busy cycles before digest_valid", busy_run, HASH_CYCLES);
			dv_total++;
			dv_row++;
			dv_ivl++;
			op_check = 1'b1;
			busy_run = 0;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		logic [`SHA_OPS_W-1:0] ops_before;
		int gap;
		reset = 1'b1;
		fire_button = 1'b0;
		void'($urandom(32'h3207)); // Fixed seed
		cycle_limit = run_cycle_limit();
		repeat (4) @(posedge clk);
		#2 reset = 1'b0;
		@(negedge clk);
		assert (!digest_valid && !busy && !rate_update) else
			stop_on_failure("digest_valid, busy or rate_update is high after reset");
		assert (stats == '0) else report_mismatch("stats", stats, 0);
		assert (digest == '0) else report_mismatch("digest", digest, 0);
		@(posedge clk);
		#2;
		for (int r = 0; r < N_ROWS; r++) begin
			ops_before = stats.op_count;
			dv_row = 0;
			drive_button(1'b1, rows[r].high);
			drive_button(1'b0, rows[r].low);
			assert (dv_row >= rows[r].min_dv && dv_row <= rows[r].max_dv) else
				stop_on_failure($sformatf(
					"ERROR digest_valid pulses in row %0d: got %0h, expected %0h to %0h",
					r, dv_row, rows[r].min_dv, rows[r].max_dv));
			assert (!busy) else
				stop_on_failure($sformatf("Hashing did not stop after release in row %0d", r));
			assert (stats.op_count == ops_before + dv_row) else
				report_mismatch("stats.op_count", stats.op_count, ops_before + dv_row);
			gap = $urandom % MAX_GAP;
			drive_button(1'b0, gap); // Idle before next row
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+rtl
rtl/sha_pkg.sv
rtl/button_debounce.sv
rtl/sha_schedule.sv
rtl/sha_core.sv
rtl/hash_sequencer.sv
rtl/op_stats.sv
rtl/sha_chip.sv
verification/sha_chip_tb.sv
